// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // Datapath
  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_aw = 5;

  // Memories
  localparam int imem_words = 64;
  localparam int imem_aw = 6;
  localparam int dmem_words = 16;
  localparam int dmem_aw = 4;

  // Opcodes
  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  // Function codes, SUB is ADD with f7_sub
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [6:0] f7_sub = 7'b0100000;

  // ALU selector
  localparam logic [1:0] alu_add = 2'd0;
  localparam logic [1:0] alu_sub = 2'd1;
  localparam logic [1:0] alu_xor = 2'd2;
  localparam logic [1:0] alu_or  = 2'd3;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_view;
  } instr_u;

endpackage

`default_nettype wire

// ==== fe_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         prog_we,
  input  logic [pipe_pkg::imem_aw-1:0] prog_addr,
  input  logic [pipe_pkg::xlen-1:0]    prog_data,
  input  logic                         de_stall,
  input  logic                         de_halt,
  output logic                         fe_valid,
  output logic [pipe_pkg::xlen-1:0]    fe_instr,
  output logic [pipe_pkg::imem_aw-1:0] fe_pc,
  output logic [pipe_pkg::xlen-1:0]    cycle_count
);

  logic [pipe_pkg::xlen-1:0]    imem [pipe_pkg::imem_words];
  logic [pipe_pkg::imem_aw-1:0] pc;
  logic                         fetch;

  assign fetch = run && !de_halt && !de_stall;

  // Program load port
  always_ff @(posedge clk) begin
    if (prog_we)
      imem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc          <= '0;
      fe_valid    <= 1'b0;
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1; // Free running
      if (fetch)
        pc <= pc + 1'b1;
      if (!de_stall)
        fe_valid <= fetch; // Hold the latch while DE stalls
    end
  end

  always_ff @(posedge clk) begin
    if (fetch) begin
      fe_instr <= imem[pc];
      fe_pc    <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== de_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module de_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        fe_valid,
  input  logic [pipe_pkg::xlen-1:0]   fe_instr,
  input  logic [pipe_pkg::reg_aw-1:0] agex_busy_rd,
  input  logic [pipe_pkg::reg_aw-1:0] mem_busy_rd,
  input  logic                        wb_we,
  input  logic [pipe_pkg::reg_aw-1:0] wb_rd,
  input  logic [pipe_pkg::xlen-1:0]   wb_data,
  output logic                        de_stall,
  output logic                        de_halt,
  output logic                        de_valid,
  output logic [1:0]                  de_alu_op,
  output logic [pipe_pkg::xlen-1:0]   de_op_a,
  output logic [pipe_pkg::xlen-1:0]   de_op_b,
  output logic [pipe_pkg::xlen-1:0]   de_store_data,
  output logic [pipe_pkg::reg_aw-1:0] de_rd,
  output logic                        de_we,
  output logic                        de_load,
  output logic                        de_store,
  output logic                        de_halt_item
);

  logic [pipe_pkg::xlen-1:0]   rf [pipe_pkg::reg_count];
  pipe_pkg::instr_u            ins;
  logic [pipe_pkg::reg_aw-1:0] rs1;
  logic [pipe_pkg::reg_aw-1:0] rs2;
  logic [pipe_pkg::reg_aw-1:0] rd;
  logic [pipe_pkg::xlen-1:0]   imm_i;
  logic [pipe_pkg::xlen-1:0]   imm_s;
  logic [pipe_pkg::xlen-1:0]   rs1_val;
  logic [pipe_pkg::xlen-1:0]   rs2_val;
  logic                        is_reg, is_imm, is_load, is_store, is_halt;
  logic                        use_rs1, use_rs2;
  logic [1:0]                  alu_op;
  logic                        halt_q;

  assign ins = fe_instr;
  assign rs1 = ins.r_view.rs1;
  assign rs2 = ins.r_view.rs2;
  assign rd  = ins.r_view.rd;
  assign imm_i = {{20{ins.i_view.imm12[11]}}, ins.i_view.imm12};
  assign imm_s = {{20{ins.s_view.imm_hi[6]}}, ins.s_view.imm_hi, ins.s_view.imm_lo};

  assign is_reg   = ins.r_view.opcode == pipe_pkg::op_reg;
  assign is_imm   = ins.r_view.opcode == pipe_pkg::op_imm;
  assign is_load  = ins.r_view.opcode == pipe_pkg::op_load;
  assign is_store = ins.r_view.opcode == pipe_pkg::op_store;
  assign is_halt  = fe_instr == '0;
  assign use_rs1  = is_reg || is_imm || is_load || is_store;
  assign use_rs2  = is_reg || is_store;

  // Write-through read, x0 is hardwired
  assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : rf[rs2];

  assign de_stall = fe_valid &&
                    ((use_rs1 && rs1 != '0 && (rs1 == agex_busy_rd || rs1 == mem_busy_rd)) ||
                     (use_rs2 && rs2 != '0 && (rs2 == agex_busy_rd || rs2 == mem_busy_rd)));
  assign de_halt = halt_q || (fe_valid && is_halt); // Stops FE in the same cycle

  always_comb begin
    alu_op = pipe_pkg::alu_add; // Loads, stores and ADDI
    if (is_reg) begin
      case (ins.r_view.funct3)
        pipe_pkg::f3_add: alu_op = (ins.r_view.funct7 == pipe_pkg::f7_sub) ?
                                   pipe_pkg::alu_sub : pipe_pkg::alu_add;
        pipe_pkg::f3_xor: alu_op = pipe_pkg::alu_xor;
        pipe_pkg::f3_or:  alu_op = pipe_pkg::alu_or;
        default:          alu_op = pipe_pkg::alu_add;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < pipe_pkg::reg_count; i++)
        rf[i] <= '0;
    end else if (wb_we && wb_rd != '0) begin
      rf[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_valid     <= 1'b0;
      de_we        <= 1'b0;
      de_load      <= 1'b0;
      de_store     <= 1'b0;
      de_halt_item <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      de_valid     <= fe_valid && !de_stall; // Bubble on hazard
      de_we        <= (is_reg || is_imm || is_load) && rd != '0;
      de_load      <= is_load;
      de_store     <= is_store;
      de_halt_item <= is_halt;
      if (fe_valid && is_halt)
        halt_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    de_alu_op     <= alu_op;
    de_op_a       <= rs1_val;
    de_op_b       <= is_reg ? rs2_val : (is_store ? imm_s : imm_i);
    de_store_data <= rs2_val;
    de_rd         <= rd;
  end

endmodule

`default_nettype wire

// ==== agex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module agex_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        de_valid,
  input  logic [1:0]                  de_alu_op,
  input  logic [pipe_pkg::xlen-1:0]   de_op_a,
  input  logic [pipe_pkg::xlen-1:0]   de_op_b,
  input  logic [pipe_pkg::xlen-1:0]   de_store_data,
  input  logic [pipe_pkg::reg_aw-1:0] de_rd,
  input  logic                        de_we,
  input  logic                        de_load,
  input  logic                        de_store,
  input  logic                        de_halt_item,
  output logic                        agex_valid,
  output logic [pipe_pkg::xlen-1:0]   agex_result,
  output logic [pipe_pkg::xlen-1:0]   agex_store_data,
  output logic [pipe_pkg::reg_aw-1:0] agex_rd,
  output logic                        agex_we,
  output logic                        agex_load,
  output logic                        agex_store,
  output logic                        agex_halt_item,
  output logic [pipe_pkg::reg_aw-1:0] agex_busy_rd
);

  logic [pipe_pkg::xlen-1:0] alu_out;

  // Address for loads and stores too
  always_comb begin
    case (de_alu_op)
      pipe_pkg::alu_sub: alu_out = de_op_a - de_op_b;
      pipe_pkg::alu_xor: alu_out = de_op_a ^ de_op_b;
      pipe_pkg::alu_or:  alu_out = de_op_a | de_op_b;
      default:           alu_out = de_op_a + de_op_b;
    endcase
  end

  assign agex_busy_rd = (de_valid && de_we) ? de_rd : '0; // Item now in AGEX

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      agex_valid     <= 1'b0;
      agex_we        <= 1'b0;
      agex_load      <= 1'b0;
      agex_store     <= 1'b0;
      agex_halt_item <= 1'b0;
    end else begin
      agex_valid     <= de_valid;
      agex_we        <= de_we;
      agex_load      <= de_load;
      agex_store     <= de_store;
      agex_halt_item <= de_halt_item;
    end
  end

  always_ff @(posedge clk) begin
    agex_result     <= alu_out;
    agex_store_data <= de_store_data;
    agex_rd         <= de_rd;
  end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        agex_valid,
  input  logic [pipe_pkg::xlen-1:0]   agex_result,
  input  logic [pipe_pkg::xlen-1:0]   agex_store_data,
  input  logic [pipe_pkg::reg_aw-1:0] agex_rd,
  input  logic                        agex_we,
  input  logic                        agex_load,
  input  logic                        agex_store,
  input  logic                        agex_halt_item,
  output logic                        mem_valid,
  output logic [pipe_pkg::xlen-1:0]   mem_result,
  output logic [pipe_pkg::reg_aw-1:0] mem_rd,
  output logic                        mem_we,
  output logic                        mem_store,
  output logic                        mem_halt_item,
  output logic [pipe_pkg::reg_aw-1:0] mem_busy_rd
);

  logic [pipe_pkg::xlen-1:0]    dmem [pipe_pkg::dmem_words];
  logic [pipe_pkg::dmem_aw-1:0] idx;

  assign idx = agex_result[pipe_pkg::dmem_aw+1:2]; // Word index, other bits ignored
  assign mem_busy_rd = (agex_valid && agex_we) ? agex_rd : '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < pipe_pkg::dmem_words; i++)
        dmem[i] <= '0;
      mem_valid     <= 1'b0;
      mem_we        <= 1'b0;
      mem_store     <= 1'b0;
      mem_halt_item <= 1'b0;
    end else begin
      if (agex_valid && agex_store)
        dmem[idx] <= agex_store_data;
      mem_valid     <= agex_valid;
      mem_we        <= agex_we;
      mem_store     <= agex_store;
      mem_halt_item <= agex_halt_item;
    end
  end

  always_ff @(posedge clk) begin
    mem_result <= agex_load ? dmem[idx] : agex_result;
    mem_rd     <= agex_rd;
  end

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        mem_valid,
  input  logic [pipe_pkg::xlen-1:0]   mem_result,
  input  logic [pipe_pkg::reg_aw-1:0] mem_rd,
  input  logic                        mem_we,
  input  logic                        mem_store,
  input  logic                        mem_halt_item,
  output logic                        wb_we,
  output logic [pipe_pkg::reg_aw-1:0] wb_rd,
  output logic [pipe_pkg::xlen-1:0]   wb_data,
  output logic                        retire_valid,
  output logic                        retire_we,
  output logic [pipe_pkg::reg_aw-1:0] retire_rd,
  output logic [pipe_pkg::xlen-1:0]   retire_data,
  output logic [pipe_pkg::xlen-1:0]   reg10_val,
  output logic                        halted
);

  logic live;

  assign live    = mem_valid && !mem_halt_item;
  assign wb_we   = live && mem_we && !mem_store; // Register file port in DE
  assign wb_rd   = mem_rd;
  assign wb_data = mem_result;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
      reg10_val    <= '0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= live;
      retire_we    <= wb_we;
      if (wb_we && wb_rd == 5'd10)
        reg10_val <= wb_data; // Shadow of x10
      if (mem_valid && mem_halt_item)
        halted <= 1'b1; // Sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    retire_rd   <= mem_rd;
    retire_data <= mem_result;
  end

endmodule

`default_nettype wire

// ==== pipe_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         prog_we,
  input  logic [pipe_pkg::imem_aw-1:0] prog_addr,
  input  logic [pipe_pkg::xlen-1:0]    prog_data,
  output logic [pipe_pkg::xlen-1:0]    cycle_count,
  output logic [pipe_pkg::xlen-1:0]    reg10_val,
  output logic                         retire_valid,
  output logic                         retire_we,
  output logic [pipe_pkg::reg_aw-1:0]  retire_rd,
  output logic [pipe_pkg::xlen-1:0]    retire_data,
  output logic                         halted
);

  // FE to DE and back
  logic                        fe_valid;
  logic [pipe_pkg::xlen-1:0]   fe_instr;
  logic                        de_stall;
  logic                        de_halt;

  // DE latch
  logic                        de_valid;
  logic [1:0]                  de_alu_op;
  logic [pipe_pkg::xlen-1:0]   de_op_a, de_op_b, de_store_data;
  logic [pipe_pkg::reg_aw-1:0] de_rd;
  logic                        de_we, de_load, de_store, de_halt_item;

  // AGEX latch
  logic                        agex_valid;
  logic [pipe_pkg::xlen-1:0]   agex_result, agex_store_data;
  logic [pipe_pkg::reg_aw-1:0] agex_rd;
  logic                        agex_we, agex_load, agex_store, agex_halt_item;

  // MEM latch
  logic                        mem_valid;
  logic [pipe_pkg::xlen-1:0]   mem_result;
  logic [pipe_pkg::reg_aw-1:0] mem_rd;
  logic                        mem_we, mem_store, mem_halt_item;

  // Feedback to DE
  logic [pipe_pkg::reg_aw-1:0] agex_busy_rd, mem_busy_rd;
  logic                        wb_we;
  logic [pipe_pkg::reg_aw-1:0] wb_rd;
  logic [pipe_pkg::xlen-1:0]   wb_data;

  fe_stage   fe_stage_i   (.*, .fe_pc());
  de_stage   de_stage_i   (.*);
  agex_stage agex_stage_i (.*);
  mem_stage  mem_stage_i  (.*);
  wb_stage   wb_stage_i   (.*);

endmodule

`default_nettype wire

// ==== pipe_core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core_checker (
  input logic                        clk,
  input logic                        reset,
  input logic [pipe_pkg::xlen-1:0]   cycle_count,
  input logic                        retire_valid,
  input logic                        retire_we,
  input logic [pipe_pkg::reg_aw-1:0] retire_rd,
  input logic                        halted
);

  // Sticky until the next reset
  halted_stays: assert property (@(posedge clk) disable iff (reset) $past(halted) |-> halted)
    else $error("halted fell without a reset");

  no_retire_after_halt: assert property (@(posedge clk) disable iff (reset)
    halted |-> !retire_valid)
    else $error("retire_valid seen after halted");

  no_x0_write: assert property (@(posedge clk) disable iff (reset)
    retire_valid && retire_we |-> retire_rd != '0)
    else $error("retire wrote x0");

  // First cycle out of reset has no previous count
  count_steps: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> cycle_count == $past(cycle_count) + 1)
    else $error("cycle_count did not step by one");

endmodule

bind pipe_core pipe_core_checker pipe_core_checker_i (.*);

`default_nettype wire

// ==== pipe_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_core_tb;

  logic                         clk;
  logic                         reset;
  logic                         run;
  logic                         prog_we;
  logic [pipe_pkg::imem_aw-1:0] prog_addr;
  logic [pipe_pkg::xlen-1:0]    prog_data;
  logic [pipe_pkg::xlen-1:0]    cycle_count;
  logic [pipe_pkg::xlen-1:0]    reg10_val;
  logic                         retire_valid;
  logic                         retire_we;
  logic [4:0]                   retire_rd;
  logic [31:0]                  retire_data;
  logic                         halted;

  logic [31:0] lfsr = 32'h61d7;
  logic [31:0] prog [64];
  logic [31:0] model_rf [32];
  logic [31:0] model_mem [16];
  logic [38:0] expected [64]; // {is_mem, we, rd, data}
  logic [38:0] item;
  logic        bad;
  int          n_exp;
  int          retired;
  int          last_retire;
  int          err_arith;
  int          err_mem;
  int          err_extra;
  int          passed;
  int          failed;
  bit          timed_out;

  pipe_core pipe_core_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Kinds 0 to 6 are ADD SUB XOR OR ADDI LW SW
  function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    case (kind)
      0: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      1: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      2: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
      3: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      4: return {imm, rs1, 3'b000, rd, 7'b0010011};
      5: return {imm, rs1, 3'b010, rd, 7'b0000011};
      default: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endcase
  endfunction

  // Random program and in-order reference model
  task automatic build_program(input int n);
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev_rd;
    logic [11:0] imm;
    logic [31:0] res;
    prev_rd = '0;
    model_rf = '{default: '0};
    model_mem = '{default: '0};
    for (int i = 0; i < n; i++) begin
      kind = int'(random_bits(3)) % 7;
      rd   = 5'(random_bits(4));
      rs1  = random_bits(1) ? prev_rd : 5'(random_bits(4)); // Bias toward hazards
      rs2  = random_bits(1) ? prev_rd : 5'(random_bits(4));
      imm  = (kind >= 5) ? 12'(random_bits(4) << 2) : 12'(random_bits(6)) - 12'd32;
      if (kind >= 5 && random_bits(1) == 1)
        rs1 = '0; // Absolute address
      case (kind)
        0: res = model_rf[rs1] + model_rf[rs2];
        1: res = model_rf[rs1] - model_rf[rs2];
        2: res = model_rf[rs1] ^ model_rf[rs2];
        3: res = model_rf[rs1] | model_rf[rs2];
        default: res = model_rf[rs1] + {{20{imm[11]}}, imm};
      endcase
      if (kind == 6)
        model_mem[res[5:2]] = model_rf[rs2];
      if (kind == 5)
        res = model_mem[res[5:2]];
      if (kind != 6 && rd != 0)
        model_rf[rd] = res;
      expected[6'(i)] = {kind >= 5, kind != 6 && rd != 0, rd, res};
      prog[6'(i)] = encode(kind, rd, rs1, rs2, imm);
      prev_rd = rd;
    end
    prog[6'(n)] = '0; // Halt
    n_exp = n;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_program(input int n);
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= 6'(i);
      prog_data <= prog[6'(i)];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    run     <= 1'b1;
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("Timeout: halted did not rise within %0d cycles", cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic report(input string name, input int errs);
    if (errs == 0) begin
      $display("Test %s: ok", name);
      passed++;
    end else begin
      $display("Test %s: FAILED with %0d errors", name, errs);
      failed++;
    end
  endtask

  // Retire monitor, in program order
  always @(negedge clk) begin
    if (reset) begin
      retired = 0;
    end else if (retire_valid) begin
      bad = 1'b0;
      if (retired >= n_exp) begin
        $display("Error at %0t: retire after the last instruction of the program", $time);
        err_extra++;
      end else begin
        item = expected[6'(retired)];
        if (retire_we !== item[37]) begin
          $display("Mismatch at %0t: retire_we got %b expected %b", $time, retire_we, item[37]);
          bad = 1'b1;
        end
        if (item[37] && retire_rd !== item[36:32]) begin
          $display("Mismatch at %0t: retire_rd got %0d expected %0d", $time, retire_rd,
                   item[36:32]);
          bad = 1'b1;
        end
        if (item[37] && retire_data !== item[31:0]) begin
          $display("Mismatch at %0t: retire_data got %h expected %h", $time, retire_data,
                   item[31:0]);
          bad = 1'b1;
        end
        if (bad && item[38])
          err_mem++;
        else if (bad)
          err_arith++;
      end
      retired++;
      last_retire = cycle_count;
    end
  end

  initial begin
    int base;
    int flow_err;
    int halt_err;
    int reset_err;
    reset     = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    reset_err = 0;
    apply_reset();
    build_program(48);
    load_program(48);
    wait_for_halt();
    report("arithmetic retire", err_arith);
    report("load and store", err_mem);
    flow_err = err_extra;
    if (retired != 48) begin
      $display("Mismatch at %0t: retired count got %0d expected 48", $time, retired);
      flow_err++;
    end
    report("hazards", flow_err);
    halt_err = timed_out ? 1 : 0;
    if (!timed_out && cycle_count - last_retire > 4) begin
      $display("Error at %0t: halted rose too late after the last retire", $time);
      halt_err++;
    end
    if (reg10_val !== model_rf[10]) begin
      $display("Mismatch at %0t: reg10_val got %h expected %h", $time, reg10_val, model_rf[10]);
      halt_err++;
    end
    report("halt", halt_err);

    // Second reset, then a short program
    base = err_arith + err_mem + err_extra;
    apply_reset();
    @(negedge clk);
    if (halted || retire_valid || reg10_val != 0 || cycle_count != 0) begin
      $display("Mismatch at %0t: halted %b retire_valid %b reg10_val %h cycle_count %0d, %s",
               $time, halted, retire_valid, reg10_val, cycle_count, "expected all zero");
      reset_err++;
    end
    repeat (3) @(negedge clk);
    if (cycle_count != 3) begin
      $display("Mismatch at %0t: cycle_count got %0d expected 3", $time, cycle_count);
      reset_err++;
    end
    build_program(12);
    load_program(12);
    wait_for_halt();
    if (retired != 12 || reg10_val !== model_rf[10]) begin
      $display("Mismatch at %0t: retired %0d reg10_val %h, expected 12 and %h", $time,
               retired, reg10_val, model_rf[10]);
      reset_err++;
    end
    reset_err += err_arith + err_mem + err_extra - base;
    report("reset state", reset_err);
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0 && !timed_out)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
pipe_pkg.sv
fe_stage.sv
de_stage.sv
agex_stage.sv
mem_stage.sv
wb_stage.sv
pipe_core.sv
pipe_core_checker.sv
pipe_core_tb.sv

// ==== Makefile ====
TOP = pipe_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

obj_dir/V$(TOP): compile.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir
